// ==== Bender.yml ====
package:
  name: char_video

sources:
  # package first, then the design
  - src/char_pkg.sv
  - src/video_timing.sv
  - src/char_vram.sv
  - src/glyph_rom.sv
  - src/char_layer.sv
  - src/char_video_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - bench/char_video_asserts.sv
      - bench/tb_char_video.sv

// ==== bench/char_video_asserts.sv ====
// char_video_asserts: reset, raster, sync/blank and rom ready checks for char_video_top
`timescale 1ns/1ps

module char_video_asserts import char_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              pxl_cen,
    input logic [POS_W-1:0]  hdump,
    input logic [POS_W-1:0]  vdump,
    input logic              hs,
    input logic              vs,
    input logic              blank,
    input logic [PXL_W-1:0]  pxl,
    input logic [DATA_W-1:0] cpu_din,
    input logic              char_ok
);

    int   fail_count = 0;   // failed assertions so far
    logic line_end;

    assign line_end = pxl_cen && hdump == POS_W'(H_TOTAL - 1);

    // outputs at reset values through reset and one clock past it
    a_reset_values: assert property (@(posedge clk)
        rst ##1 1'b1 |-> pxl == '0 && !hs && !vs && cpu_din == '0 && blank)
    else begin
        $error("outputs not at reset values");
        fail_count++;
    end

    // last pixel of a line, wrap h and step v
    a_line_wrap: assert property (@(posedge clk) disable iff (rst)
        line_end |=> hdump == '0 &&
            vdump == (($past(vdump) == V_TOTAL - 1) ? 0 : $past(vdump) + 1))
    else begin
        $error("raster did not wrap to the next line");
        fail_count++;
    end

    // inside a line h counts up, v holds
    a_pixel_step: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && !line_end |=> hdump == $past(hdump) + 1 && $stable(vdump))
    else begin
        $error("hdump did not step by one pixel");
        fail_count++;
    end

    // decodes settle with the new position
    a_sync_blank: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> hs == (hdump >= HS_START && hdump < HS_END) &&
            vs == (vdump >= VS_START && vdump < VS_END) &&
            blank == !(hdump < H_VISIBLE && vdump < V_VISIBLE))
    else begin
        $error("sync or blank out of place");
        fail_count++;
    end

    // planes load at the tile edge, rom must be done by then
    a_rom_ready: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && hdump[2:0] == 3'd7 |-> char_ok)
    else begin
        $error("glyph rom not ready at tile load");
        fail_count++;
    end

endmodule

bind char_video_top char_video_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .pxl_cen (pos.pxl_cen),
    .hdump   (hdump),
    .vdump   (vdump),
    .hs      (hs),
    .vs      (vs),
    .blank   (blank),
    .pxl     (pxl),
    .cpu_din (cpu_din),
    .char_ok (char_ok)
);

// ==== bench/tb_char_video.sv ====
// tb_char_video: clock, reset, cpu map fill and read-back, pixel model, closing summary
`timescale 1ns/1ps

module tb_char_video import char_pkg::*;;

    localparam int FRAME_CLKS = CEN_DIV * H_TOTAL * V_TOTAL;
    localparam int GLYPHS     = 6;          // codes in the hex file

    logic              rst;
    logic              clk;
    logic              char_cs;
    logic [MAP_AW-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_dout;
    logic [LANES-1:0]  dsn;
    logic [DATA_W-1:0] cpu_din;
    logic              hs;
    logic              vs;
    logic              blank;
    logic [POS_W-1:0]  hdump;
    logic [POS_W-1:0]  vdump;
    logic [PXL_W-1:0]  pxl;
    logic              pxl_cen;

    logic [DATA_W-1:0] map_model [2**MAP_AW];   // what the cpu wrote
    logic [ROM_DW-1:0] glyph [GLYPHS*16];       // same image as the dut rom
    logic [31:0]       rng;
    int                map_errors;
    int                pixel_errors;
    int                pixel_checks;
    int                timeouts;

    char_video_top u_dut (
        .rst      (rst),
        .clk      (clk),
        .char_cs  (char_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (cpu_din),
        .hs       (hs),
        .vs       (vs),
        .blank    (blank),
        .hdump    (hdump),
        .vdump    (vdump),
        .pxl      (pxl)
    );

    assign pxl_cen = u_dut.pos.pxl_cen;     // pixel strobe from inside

    initial clk = 1'b0;
    always #4 clk = ~clk;                   // 8 ns

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // code 0..5 low, attr and spare nibble random
    function automatic logic [DATA_W-1:0] random_map_word(input logic [31:0] r);
        return {r[23:20], r[11:8], 8'(r % 6)};
    endfunction

    // byte lanes with dsn low take the new byte
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [LANES-1:0]  sel_n
    );
        logic [DATA_W-1:0] w;
        w = old_word;
        for (int i = 0; i < LANES; i++) begin
            if (!sel_n[i]) begin
                w[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return w;
    endfunction

    // tile c shows at h = 8(c+2)+k, bit 7-k of each plane
    function automatic logic [PXL_W-1:0] expected_pixel(input int v, input int h);
        int                c;
        int                k;
        logic [DATA_W-1:0] w;
        logic [ROM_DW-1:0] g;
        c = h / 8 - 2;
        k = h % 8;
        w = map_model[(v / 8) * 64 + c];
        g = glyph[w[7:0] * 16 + (v % 8) * 2];
        return {w[ATTR_MSB:ATTR_LSB], g[16 + 7 - k], g[8 + 7 - k], g[7 - k]};
    endfunction

    task automatic write_word(
        input logic [MAP_AW-1:0] a,
        input logic [DATA_W-1:0] d,
        input logic [LANES-1:0]  sel_n
    );
        @(posedge clk);
        char_cs  <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
        dsn      <= sel_n;
        map_model[a] = merge_bytes(map_model[a], d, sel_n);
    endtask

    // read cycle, data back one clock later
    task automatic read_check(input logic [MAP_AW-1:0] a);
        @(posedge clk);
        char_cs  <= 1'b1;
        cpu_addr <= a;
        dsn      <= '1;
        @(posedge clk);
        char_cs  <= 1'b0;
        @(negedge clk);
        assert (cpu_din === map_model[a]) else begin
            $display("Fail %0t: map read at %h got %h, expected %h",
                     $time, a, cpu_din, map_model[a]);
            map_errors++;
        end
    endtask

    task automatic wait_frame_start(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 2 * FRAME_CLKS && !ok; n++) begin
            @(negedge clk);
            ok = pxl_cen && hdump == '0 && vdump == '0;
        end
        if (!ok) begin
            $display("timeout waiting for the start of a frame");
            timeouts++;
        end
    endtask

    // visible lines only, first two tiles of a line belong to the last line
    task automatic check_frame;
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < FRAME_CLKS && !done; n++) begin
            @(negedge clk);
            if (pxl_cen) begin
                if (vdump >= V_VISIBLE) begin
                    done = 1'b1;
                end else if (hdump >= 16 && hdump < H_VISIBLE) begin
                    pixel_checks++;
                    assert (pxl === expected_pixel(vdump, hdump)) else begin
                        $display("Fail %0t: pixel at line %0d h %0d got %h, expected %h",
                                 $time, vdump, hdump, pxl, expected_pixel(vdump, hdump));
                        pixel_errors++;
                    end
                end
            end
        end
        if (!done) begin
            $display("timeout before the end of the visible lines");
            timeouts++;
        end
    endtask

    initial begin
        bit                ok;
        int                a;
        int                i;
        logic [MAP_AW-1:0] addr;
        rng          = 32'd34214;
        map_errors   = 0;
        pixel_errors = 0;
        pixel_checks = 0;
        timeouts     = 0;
        rst      = 1'b1;
        char_cs  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn      = '1;
        $readmemh("src/glyph_rom.hex", glyph);
        @(posedge clk);
        $readmemh("src/glyph_rom.hex", u_dut.u_rom.rom);   // dut rom from the root copy
        repeat (15) @(posedge clk);
        rst <= 1'b0;
        // whole map, one word per clock stays ahead of the scan
        for (a = 0; a < 2**MAP_AW; a++) begin
            rng = xorshift32(rng);
            write_word(MAP_AW'(a), random_map_word(rng), '0);
        end
        // byte lane writes, every dsn pattern, each read back
        for (i = 0; i < 16; i++) begin
            rng  = xorshift32(rng);
            addr = MAP_AW'(rng >> 16);
            rng  = xorshift32(rng);
            write_word(addr, random_map_word(rng), LANES'(i % 4));
            read_check(addr);
        end
        wait_frame_start(ok);
        if (ok) begin
            check_frame();
        end
        $display("pixel checks %0d, errors: map %0d, pixel %0d, assertion %0d, timeout %0d",
                 pixel_checks, map_errors, pixel_errors,
                 u_dut.u_asserts.fail_count, timeouts);
        if (map_errors + pixel_errors + u_dut.u_asserts.fail_count + timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/char_pkg.sv
src/video_timing.sv
src/char_vram.sv
src/glyph_rom.sv
src/char_layer.sv
src/char_video_top.sv
bench/char_video_asserts.sv
bench/tb_char_video.sv

// ==== src/char_layer.sv ====
// char_layer: tile fetch, glyph addressing and plane shifter for the text layer
`timescale 1ns/1ps

module char_layer import char_pkg::*; (
    input  logic              rst,
    input  logic              clk,
    video_pos_if.sink         pos,
    output logic [MAP_AW-1:0] scan_addr,
    input  logic [DATA_W-1:0] scan,
    output logic [ROM_AW-1:0] char_addr,
    input  logic [ROM_DW-1:0] char_data,
    input  logic              char_ok,
    output logic [PXL_W-1:0]  pxl
);

    logic [DATA_W-1:0]              scan_q;   // map word, steady copy
    logic [CODE_W-1:0]              code;     // glyph of the tile being fetched
    logic [ATTR_W-1:0]              attr0;    // attr waiting for its glyph
    logic [ATTR_W-1:0]              attr;     // attr of the tile on screen
    logic [PLANES-1:0][PLANE_W-1:0] planes;   // shift registers, msb out
    logic                           tile_end;

    // map row from vdump, map column from hdump
    assign scan_addr = {pos.vdump[7:3], pos.hdump[8:3]};
    // code, glyph row, word select always low
    assign char_addr = {code, pos.vdump[2:0], 1'b0};

    assign tile_end = pos.hdump[2:0] == 3'd7;

    // ram output moves every clock, sample it at mid pixel
    always_ff @(posedge clk) begin
        if (pos.pxl2_cen) begin
            scan_q <= scan;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code   <= '0;
            attr0  <= '0;
            attr   <= '0;
            planes <= '0;
        end else if (pos.pxl_cen) begin
            if (tile_end) begin
                // next tile into the fetch stage
                code  <= {1'b0, scan_q[CODE_MSB:0]};
                attr0 <= scan_q[ATTR_MSB:ATTR_LSB];
                // previous tile goes on screen
                attr  <= attr0;
                for (int p = 0; p < PLANES; p++) begin
                    // rom not ready shows as colour 0
                    planes[p] <= char_ok ? char_data[p*PLANE_W +: PLANE_W] : '0;
                end
            end else begin
                for (int p = 0; p < PLANES; p++) begin
                    planes[p] <= planes[p] << 1;  // next pixel to msb
                end
            end
        end
    end

    // char_data[31:24] is a fourth plane, unused by this layer
    assign pxl = {attr,
                  planes[2][PLANE_W-1],
                  planes[1][PLANE_W-1],
                  planes[0][PLANE_W-1]};

endmodule

// ==== src/char_pkg.sv ====
// char_pkg constants for raster, map and glyph fields, plus cpu_bus_if and video_pos_if
`timescale 1ns/1ps

package char_pkg;

    // raster, in pixels and lines
    localparam int POS_W     = 9;       // hdump / vdump width
    localparam int H_TOTAL   = 384;
    localparam int V_TOTAL   = 262;
    localparam int H_VISIBLE = 320;
    localparam int V_VISIBLE = 224;
    localparam int HS_START  = 336;     // hs high for HS_START <= h < HS_END
    localparam int HS_END    = 368;
    localparam int VS_START  = 240;
    localparam int VS_END    = 243;

    // clock enables
    localparam int CEN_DIV = 4;         // clocks per pxl_cen
    localparam int CEN_W   = $clog2(CEN_DIV);

    // character map, 32 rows x 64 cols of 16-bit words
    localparam int MAP_AW = 11;
    localparam int DATA_W = 16;
    localparam int LANES  = DATA_W / 8; // byte lanes, one dsn bit each

    // map word fields
    localparam int CODE_MSB = 7;        // code[8] is tied low
    localparam int CODE_W   = 9;
    localparam int ATTR_LSB = 8;        // priority + 3 palette bits
    localparam int ATTR_MSB = 11;
    localparam int ATTR_W   = ATTR_MSB - ATTR_LSB + 1;

    // glyph rom: code, glyph row, word select
    localparam int ROM_AW      = 13;
    localparam int ROM_DW      = 32;
    localparam int ROM_LATENCY = 2;
    localparam int LAT_W       = $clog2(ROM_LATENCY + 1);
    localparam string ROM_FILE = "glyph_rom.hex";

    // pixel = attr followed by one bit per plane
    localparam int PLANES  = 3;
    localparam int PLANE_W = 8;         // 8 pixels per plane byte
    localparam int PXL_W   = ATTR_W + PLANES;

endpackage

// cpu side of the character map
interface cpu_bus_if import char_pkg::*; ();
    logic              cs;
    logic [MAP_AW-1:0] addr;    // word address
    logic [DATA_W-1:0] dout;    // cpu write data
    logic [LANES-1:0]  dsn;     // active low byte selects
    logic [DATA_W-1:0] din;     // read data back to cpu

    modport host (output cs, addr, dout, dsn, input din);
    modport ram  (input cs, addr, dout, dsn, output din);
endinterface

// raster position and enables from the timing block
interface video_pos_if import char_pkg::*; ();
    logic             pxl_cen;
    logic             pxl2_cen;
    logic [POS_W-1:0] hdump;
    logic [POS_W-1:0] vdump;

    modport source (output pxl_cen, pxl2_cen, hdump, vdump);
    modport sink   (input pxl_cen, pxl2_cen, hdump, vdump);
endinterface

// ==== src/char_video_top.sv ====
// char_video_top: timing, character map, glyph rom and text layer
`timescale 1ns/1ps

module char_video_top import char_pkg::*; (
    input  logic              rst,
    input  logic              clk,
    // cpu map access
    input  logic              char_cs,
    input  logic [MAP_AW-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_dout,
    input  logic [LANES-1:0]  dsn,       // low = write that byte
    output logic [DATA_W-1:0] cpu_din,
    // video out
    output logic              hs,
    output logic              vs,
    output logic              blank,
    output logic [POS_W-1:0]  hdump,
    output logic [POS_W-1:0]  vdump,
    output logic [PXL_W-1:0]  pxl
);

    cpu_bus_if   bus ();
    video_pos_if pos ();

    logic [MAP_AW-1:0] scan_addr;
    logic [DATA_W-1:0] scan;
    logic [ROM_AW-1:0] char_addr;
    logic [ROM_DW-1:0] char_data;
    logic              char_ok;

    // plain cpu ports onto the bus
    assign bus.cs   = char_cs;
    assign bus.addr = cpu_addr;
    assign bus.dout = cpu_dout;
    assign bus.dsn  = dsn;
    assign cpu_din  = bus.din;

    assign hdump = pos.hdump;    // raster position for the outside
    assign vdump = pos.vdump;

    video_timing u_timing (
        .rst   (rst),
        .clk   (clk),
        .pos   (pos),
        .hs    (hs),
        .vs    (vs),
        .blank (blank)
    );

    char_vram u_vram (
        .rst       (rst),
        .clk       (clk),
        .bus       (bus),
        .scan_addr (scan_addr),
        .scan      (scan)
    );

    glyph_rom u_rom (
        .clk       (clk),
        .rst       (rst),
        .char_addr (char_addr),
        .char_data (char_data),
        .char_ok   (char_ok)
    );

    char_layer u_layer (
        .rst       (rst),
        .clk       (clk),
        .pos       (pos),
        .scan_addr (scan_addr),
        .scan      (scan),
        .char_addr (char_addr),
        .char_data (char_data),
        .char_ok   (char_ok),
        .pxl       (pxl)
    );

endmodule

// ==== src/char_vram.sv ====
// char_vram: dual port character map, cpu byte writes and registered video reads
`timescale 1ns/1ps

module char_vram import char_pkg::*; (
    input  logic              rst,
    input  logic              clk,
    cpu_bus_if.ram            bus,
    input  logic [MAP_AW-1:0] scan_addr,   // video read address
    output logic [DATA_W-1:0] scan         // map word, one clock later
);

    logic [DATA_W-1:0] mem [2**MAP_AW];    // 2048 words
    logic [DATA_W-1:0] cpu_q;              // last cpu read

    // cpu port, per byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (bus.cs && !bus.dsn[i]) begin
                mem[bus.addr][8*i +: 8] <= bus.dout[8*i +: 8];
            end
        end
    end

    // cpu read, old contents on a write cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_q <= '0;
        end else if (bus.cs) begin
            cpu_q <= mem[bus.addr];
        end                                // held while cs low
    end

    assign bus.din = cpu_q;

    // video port, read only
    always_ff @(posedge clk) begin
        scan <= mem[scan_addr];
    end

endmodule

// ==== src/glyph_rom.hex ====
// glyph rows at code*16 + row*2, byte 3 spare plane, bytes 2..0 planes 2..0
// four words per line: row 2k, pad, row 2k+1, pad
11ff00ff 00000000 22810081 00000000
33810081 00000000 44810081 00000000
55810081 00000000 66810081 00000000
77810081 00000000 88ff00ff 00000000
0a183c18 00000000 0b383c38 00000000
0c181818 00000000 0d18ff18 00000000
0e181818 00000000 0f18ff18 00000000
107e7e7e 00000000 11000000 00000000
00aa55aa 00000000 0055aa55 00000000
00aa55aa 00000000 0055aa55 00000000
00aa55aa 00000000 0055aa55 00000000
00aa55aa 00000000 0055aa55 00000000
c3800180 00000000 c3400240 00000000
c3200420 00000000 c3100810 00000000
c3081008 00000000 c3042004 00000000
c3024002 00000000 c3018001 00000000
5a0f0ff0 00000000 5a1e1ee1 00000000
5a3c3cc3 00000000 5a787887 00000000
5af0f00f 00000000 5ae1e11e 00000000
5ac3c33c 00000000 5a878778 00000000
99fe3c00 00000000 99c066c6 00000000
99c066ce 00000000 99fc66de 00000000
99c07ef6 00000000 99c066e6 00000000
99fe66c6 00000000 997c0000 00000000

// ==== src/glyph_rom.sv ====
// glyph_rom: glyph row rom with fixed read latency and ok strobe
`timescale 1ns/1ps

module glyph_rom import char_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ROM_AW-1:0] char_addr,
    output logic [ROM_DW-1:0] char_data,   // three planes in [23:0]
    output logic              char_ok
);

    logic [ROM_DW-1:0] rom  [2**ROM_AW];
    logic [ROM_DW-1:0] pipe [ROM_LATENCY]; // read pipeline
    logic [ROM_AW-1:0] addr_q;             // address seen last clock
    logic [LAT_W-1:0]  stage;              // pipe stages holding current addr

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    always_ff @(posedge clk) begin
        pipe[0] <= rom[char_addr];
        for (int i = 1; i < ROM_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign char_data = pipe[ROM_LATENCY-1];

    // stage count restarts on every new address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
            stage  <= '0;
        end else begin
            addr_q <= char_addr;
            if (char_addr != addr_q) begin
                stage <= LAT_W'(1);        // first stage just loaded
            end else if (stage != LAT_W'(ROM_LATENCY)) begin
                stage <= stage + 1'b1;
            end
        end
    end

    assign char_ok = stage == LAT_W'(ROM_LATENCY);  // whole pipe holds addr

endmodule

// ==== src/video_timing.sv ====
// video_timing: pixel clock enables, raster counters, sync and blank
`timescale 1ns/1ps

module video_timing import char_pkg::*; (
    input  logic        rst,
    input  logic        clk,
    video_pos_if.source pos,
    output logic        hs,
    output logic        vs,
    output logic        blank
);

    logic [CEN_W-1:0] cen_cnt;     // free running divider
    logic [POS_W-1:0] h_next;
    logic [POS_W-1:0] v_next;
    logic             h_wrap;

    // enables, pxl2 every 2 clocks and pxl on every other pxl2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt      <= '0;
            pos.pxl2_cen <= 1'b0;
            pos.pxl_cen  <= 1'b0;
        end else begin
            cen_cnt      <= cen_cnt + 1'b1;   // CEN_DIV is a power of two
            pos.pxl2_cen <= cen_cnt[0];
            pos.pxl_cen  <= cen_cnt == CEN_W'(CEN_DIV - 1);
        end
    end

    assign h_wrap = pos.hdump == POS_W'(H_TOTAL - 1);

    // next raster position
    always_comb begin
        h_next = h_wrap ? '0 : pos.hdump + 1'b1;
        v_next = pos.vdump;
        if (h_wrap) begin
            // line done, step to next line
            v_next = (pos.vdump == POS_W'(V_TOTAL - 1)) ? '0 : pos.vdump + 1'b1;
        end
    end

    // decodes use the next position so they line up with hdump/vdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos.hdump <= '0;
            pos.vdump <= '0;
            hs        <= 1'b0;
            vs        <= 1'b0;
            blank     <= 1'b1;
        end else if (pos.pxl_cen) begin
            pos.hdump <= h_next;
            pos.vdump <= v_next;
            hs        <= h_next >= POS_W'(HS_START) && h_next < POS_W'(HS_END);
            vs        <= v_next >= POS_W'(VS_START) && v_next < POS_W'(VS_END);
            // active area is top left corner
            blank     <= !(h_next < POS_W'(H_VISIBLE) && v_next < POS_W'(V_VISIBLE));
        end
    end

endmodule
